// ==== compile.f ====
+incdir+src
src/cache_pkg.sv
src/req_fifo.sv
src/plru_tree.sv
src/cache.sv
src/mem_ctrl.sv
src/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_mem_subsys -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
exit 0

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module tb_mem_subsys;

  import cache_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_SETS    = `CACHE_BYTES / `LINE_BYTES / `CACHE_WAYS;
  localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
  localparam int SET_BITS    = $clog2(NUM_SETS);
  localparam int WORD_BYTES  = `WORD_BITS / 8;
  localparam int LINE_WORDS  = `LINE_BYTES / WORD_BYTES;
  localparam int POOL_TAGS   = `CACHE_WAYS + 2;  // more tags than ways, sets overflow
  localparam int COLD_READS  = 8;
  localparam int RAW_PAIRS   = 12;
  localparam int MIX_REQS    = 400;
  localparam int BP_REQS     = 200;
  localparam int TOTAL_REQS  = COLD_READS + 2 * RAW_PAIRS + 2 * POOL_TAGS + MIX_REQS + BP_REQS;
  // dirty miss: write-back and line read, plus idle, two lookups, two pushes, respond
  localparam int WORST_CYCLES = 2 * (`MEM_LATENCY + 1) + 6;
  localparam int DRAIN_CYCLES = (`FIFO_DEPTH + 2) * WORST_CYCLES * 4;
  localparam int WATCHDOG_NS  = (TOTAL_REQS * WORST_CYCLES * 3 + 5 * DRAIN_CYCLES) * CLK_PERIOD;

  logic  clk_in = 1'b0;
  logic  rst_N_in;
  logic  req_valid;
  logic  req_ready;
  logic  req_we;
  addr_t req_addr;
  word_t req_wdata;
  logic  resp_valid;
  logic  resp_ready;
  addr_t resp_addr;
  word_t resp_data;

  word_t model [addr_t];  // flat memory, missing entries read as zero
  addr_t exp_addr_q [$];  // outstanding reads in request order
  word_t exp_data_q [$];
  int    err_cnt;
  int    req_cnt;
  int    resp_cnt;
  logic  bp_mode;         // random resp_ready when set
  logic  saw_stall_full;  // req_ready low while a response waits

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  mem_subsys_top DUT (
    .clk_in     (clk_in),     .rst_N_in   (rst_N_in),
    .req_valid  (req_valid),  .req_ready  (req_ready),
    .req_we     (req_we),     .req_addr   (req_addr),   .req_wdata (req_wdata),
    .resp_valid (resp_valid), .resp_ready (resp_ready),
    .resp_addr  (resp_addr),  .resp_data  (resp_data)
  );

  function automatic word_t model_read(input addr_t addr);
    return model.exists(addr) ? model[addr] : '0;
  endfunction

  // tag | set | word | byte, tags spread so they stay distinct
  function automatic addr_t make_addr(input int tag_sel, input int set, input int word);
    addr_t tag;
    tag = addr_t'(tag_sel * 97 + 3);
    return (tag << (SET_BITS + OFFSET_BITS)) | addr_t'(set << OFFSET_BITS)
           | addr_t'(word * WORD_BYTES);
  endfunction

  function automatic addr_t rand_addr();
    return make_addr(int'($urandom % POOL_TAGS), int'($urandom % NUM_SETS),
                     int'($urandom % LINE_WORDS));
  endfunction

  // holds valid until req_ready, model follows the accepted order
  task automatic send_req(input logic we, input addr_t addr, input word_t wdata);
    @(negedge clk_in);
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    while (!req_ready) @(negedge clk_in);
    if (we) begin
      model[addr] = wdata;
    end else begin
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(model_read(addr));
    end
    req_cnt++;  // transfer lands on the coming rising edge
  endtask

  task automatic drain_and_report(input string name, input int errs0, input int resp0);
    int n;
    n = 0;
    @(negedge clk_in);
    req_valid = 1'b0;
    while (exp_addr_q.size() > 0 && n < DRAIN_CYCLES) begin
      @(negedge clk_in);
      n++;
    end
    assert (exp_addr_q.size() == 0) else begin
      $display("error at %0t: %0d read responses never arrived in test %s",
               $time, exp_addr_q.size(), name);
      err_cnt++;
    end
    $display("test %s done: %0d responses checked, %0d errors", name,
             resp_cnt - resp0, err_cnt - errs0);
  endtask

  task automatic check_resp();
    addr_t exp_addr;
    word_t exp_data;
    assert (exp_addr_q.size() > 0) else begin
      $display("error at %0t: response for %h with no read outstanding", $time, resp_addr);
      err_cnt++;
    end
    if (exp_addr_q.size() > 0) begin
      exp_addr = exp_addr_q.pop_front();
      exp_data = exp_data_q.pop_front();
      resp_cnt++;
      assert (resp_addr == exp_addr) else begin
        $display("Mismatch at %0t: resp_addr %h, expected %h", $time, resp_addr, exp_addr);
        err_cnt++;
      end
      assert (resp_data == exp_data) else begin
        $display("Mismatch at %0t: resp_data %h for %h, expected %h", $time, resp_data,
                 exp_addr, exp_data);
        err_cnt++;
      end
    end
  endtask

  // response side, resp_ready set and the transfer judged on the same falling edge
  always @(negedge clk_in) begin
    resp_ready = bp_mode ? ($urandom % 4 == 0) : 1'b1;
    if (bp_mode && resp_valid && !resp_ready && !req_ready) saw_stall_full = 1'b1;
    if (rst_N_in && resp_valid && resp_ready) check_resp();
  end

  task automatic run_mix(input string name, input int count);
    int errs0;
    int resp0;
    addr_t addr;
    errs0 = err_cnt;
    resp0 = resp_cnt;
    for (int i = 0; i < count; i++) begin
      addr = rand_addr();
      send_req(logic'($urandom % 2), addr, $urandom);
    end
    drain_and_report(name, errs0, resp0);
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run still active after %0d ns, a response or request is stuck",
             WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    int errs0;
    int resp0;
    addr_t addr;
    word_t data;
    void'($urandom(32'h5757));
    rst_N_in = 1'b0;
    req_valid = 1'b0;
    req_we = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    resp_ready = 1'b1;
    bp_mode = 1'b0;
    saw_stall_full = 1'b0;
    err_cnt = 0;
    req_cnt = 0;
    resp_cnt = 0;
    repeat (5) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b1;

    // nothing written yet, every read returns zero
    errs0 = err_cnt;
    resp0 = resp_cnt;
    for (int i = 0; i < COLD_READS; i++) send_req(1'b0, rand_addr(), '0);
    drain_and_report("cold_reads", errs0, resp0);

    errs0 = err_cnt;
    resp0 = resp_cnt;
    for (int i = 0; i < RAW_PAIRS; i++) begin
      addr = rand_addr();
      data = $urandom;
      send_req(1'b1, addr, data);
      send_req(1'b0, addr, '0);
    end
    drain_and_report("read_after_write", errs0, resp0);

    // one set, more tags than ways, dirty victims must survive the round trip
    errs0 = err_cnt;
    resp0 = resp_cnt;
    for (int t = 0; t < POOL_TAGS; t++) send_req(1'b1, make_addr(t, 1, t % LINE_WORDS), $urandom);
    for (int t = 0; t < POOL_TAGS; t++) send_req(1'b0, make_addr(t, 1, t % LINE_WORDS), '0);
    drain_and_report("eviction", errs0, resp0);

    run_mix("random_mix", MIX_REQS);

    bp_mode = 1'b1;
    run_mix("back_pressure", BP_REQS);
    bp_mode = 1'b0;
    assert (saw_stall_full) else begin
      $display("error: req_ready never fell while a response was stalled");
      err_cnt++;
    end

    repeat (2 * WORST_CYCLES) @(negedge clk_in);  // trailing write-backs settle
    $display("summary: %0d requests, %0d responses checked, %0d errors",
             req_cnt, resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic             clk_in,
  input  logic             rst_N_in,
  input  logic             req_valid,
  output logic             req_ready,
  input  logic             req_we,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::word_t req_wdata,
  output logic             resp_valid,
  input  logic             resp_ready,
  output cache_pkg::addr_t resp_addr,
  output cache_pkg::word_t resp_data
);

  import cache_pkg::*;

  cache_req_t req_in;    // loose ports packed
  cache_req_t req_head;
  logic       req_full;
  logic       req_empty;
  logic       req_pop;
  mem_cmd_t   cmd_in;
  mem_cmd_t   cmd_head;
  logic       cmd_push;
  logic       cmd_full;
  logic       cmd_pop;
  logic       cmd_empty;
  logic       fill_valid;
  line_t      fill_line;

  assign req_in    = '{we: req_we, addr: req_addr, wdata: req_wdata};
  assign req_ready = !req_full;

  // host request buffer
  req_fifo #(.payload_t(cache_req_t)) u_req_fifo (
    .clk_in    (clk_in),    .rst_N_in (rst_N_in),
    .push      (req_valid), .push_data (req_in),   .full  (req_full),
    .pop       (req_pop),   .pop_data  (req_head), .empty (req_empty)
  );

  cache u_cache (
    .clk_in     (clk_in),     .rst_N_in   (rst_N_in),
    .req_empty  (req_empty),  .req_head   (req_head),   .req_pop   (req_pop),
    .cmd_full   (cmd_full),   .cmd_push   (cmd_push),   .cmd_data  (cmd_in),
    .fill_valid (fill_valid), .fill_line  (fill_line),
    .resp_valid (resp_valid), .resp_ready (resp_ready),
    .resp_addr  (resp_addr),  .resp_data  (resp_data)
  );

  // memory command buffer
  req_fifo #(.payload_t(mem_cmd_t)) u_cmd_fifo (
    .clk_in    (clk_in),   .rst_N_in (rst_N_in),
    .push      (cmd_push), .push_data (cmd_in),   .full  (cmd_full),
    .pop       (cmd_pop),  .pop_data  (cmd_head), .empty (cmd_empty)
  );

  mem_ctrl u_mem_ctrl (
    .clk_in     (clk_in),     .rst_N_in (rst_N_in),
    .cmd_empty  (cmd_empty),  .cmd_head (cmd_head), .cmd_pop (cmd_pop),
    .fill_valid (fill_valid), .fill_line (fill_line)
  );

endmodule

// ==== src/mem_ctrl.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module mem_ctrl (
  input  logic                clk_in,
  input  logic                rst_N_in,
  input  logic                cmd_empty,
  input  cache_pkg::mem_cmd_t cmd_head,
  output logic                cmd_pop,
  output logic                fill_valid,
  output cache_pkg::line_t    fill_line
);

  import cache_pkg::*;

  localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
  localparam int IDX_BITS    = `ADDR_BITS - OFFSET_BITS;
  localparam int NUM_LINES   = 1 << IDX_BITS;  // full address space
  localparam int LAT_BITS    = $clog2(`MEM_LATENCY + 1);

  line_t               mem [NUM_LINES];
  mem_cmd_t            cmd_q;      // command in service
  logic                busy_q;
  logic [LAT_BITS-1:0] lat_cnt_q;  // cycles left before access
  logic                access;     // last busy cycle
  logic [IDX_BITS-1:0] line_idx;

  assign cmd_pop  = !busy_q && !cmd_empty;  // one command per idle slot
  assign access   = busy_q && (lat_cnt_q == '0);
  assign line_idx = cmd_q.addr[`ADDR_BITS-1:OFFSET_BITS];

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      busy_q     <= 1'b0;
      lat_cnt_q  <= '0;
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= access && !cmd_q.we;  // single cycle pulse, reads only
      if (cmd_pop) begin
        busy_q    <= 1'b1;
        lat_cnt_q <= LAT_BITS'(`MEM_LATENCY - 1);
      end else if (access) begin
        busy_q <= 1'b0;  // writes finish silently
      end else if (busy_q) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (cmd_pop) cmd_q <= cmd_head;
    if (access && !cmd_q.we) fill_line <= mem[line_idx];
  end

  // backing store, zeroed on reset
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (access && cmd_q.we) begin
      mem[line_idx] <= cmd_q.data;  // absorb write-back
    end
  end

endmodule

// ==== src/cache.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module cache (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  // request buffer head
  input  logic                  req_empty,
  input  cache_pkg::cache_req_t req_head,
  output logic                  req_pop,
  // memory command buffer
  input  logic                  cmd_full,
  output logic                  cmd_push,
  output cache_pkg::mem_cmd_t   cmd_data,
  // line fill back from memory
  input  logic                  fill_valid,
  input  cache_pkg::line_t      fill_line,
  // word responses, reads only
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output cache_pkg::addr_t      resp_addr,
  output cache_pkg::word_t      resp_data
);

  import cache_pkg::*;

  localparam int NUM_SETS      = `CACHE_BYTES / `LINE_BYTES / `CACHE_WAYS;
  localparam int OFFSET_BITS   = $clog2(`LINE_BYTES);
  localparam int SET_BITS      = $clog2(NUM_SETS);
  localparam int TAG_BITS      = `ADDR_BITS - SET_BITS - OFFSET_BITS;
  localparam int WAY_BITS      = $clog2(`CACHE_WAYS);
  localparam int BYTE_SEL_BITS = $clog2(`WORD_BITS / 8);
  localparam int WORD_SEL_BITS = OFFSET_BITS - BYTE_SEL_BITS;

  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_writeback,   // push dirty victim
    s_fetch,       // push line read
    s_fill_wait,
    s_write_cache, // merge word on write hit
    s_respond
  } state_t;

  tag_entry_t tag_array  [`CACHE_WAYS][NUM_SETS];
  line_t      data_array [`CACHE_WAYS][NUM_SETS];

  state_t                   state_q;
  state_t                   state_d;
  cache_req_t               req_q;      // request being served
  logic [WAY_BITS-1:0]      hit_way_q;
  logic [WAY_BITS-1:0]      victim_q;
  logic [TAG_BITS-1:0]      req_tag;
  logic [SET_BITS-1:0]      req_set;
  logic [WORD_SEL_BITS-1:0] req_word;   // word within the line
  logic                     hit;
  logic [WAY_BITS-1:0]      hit_way;
  logic [WAY_BITS-1:0]      plru_victim;
  logic                     touch;
  logic [WAY_BITS-1:0]      touch_way;

  // address split, tag | set | word | byte
  assign req_tag  = req_q.addr[`ADDR_BITS-1 -: TAG_BITS];
  assign req_set  = req_q.addr[OFFSET_BITS +: SET_BITS];
  assign req_word = req_q.addr[BYTE_SEL_BITS +: WORD_SEL_BITS];

  assign resp_addr = req_q.addr;
  assign resp_data = data_array[hit_way_q][req_set][req_word*`WORD_BITS +: `WORD_BITS];

  // tag compare across all ways of the set
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (tag_array[w][req_set].valid && tag_array[w][req_set].tag == req_tag) begin
        hit     = 1'b1;
        hit_way = WAY_BITS'(w);
      end
    end
  end

  plru_tree u_plru (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .set_idx    (req_set),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim_way (plru_victim)
  );

  always_comb begin
    state_d    = state_q;
    req_pop    = 1'b0;
    cmd_push   = 1'b0;
    cmd_data   = '0;
    resp_valid = 1'b0;
    touch      = 1'b0;
    touch_way  = hit_way;
    case (state_q)
      s_idle: begin
        req_pop = !req_empty;  // take the head only from idle
        if (!req_empty) state_d = s_lookup;
      end
      s_lookup: begin
        if (hit) begin
          touch   = 1'b1;
          state_d = req_q.we ? s_write_cache : s_respond;
        end else if (tag_array[plru_victim][req_set].dirty) begin
          state_d = s_writeback;  // victim must go out first
        end else begin
          state_d = s_fetch;
        end
      end
      s_writeback: begin
        cmd_push      = !cmd_full;
        cmd_data.we   = 1'b1;
        cmd_data.addr = {tag_array[victim_q][req_set].tag, req_set, {OFFSET_BITS{1'b0}}};
        cmd_data.data = data_array[victim_q][req_set];
        if (!cmd_full) state_d = s_fetch;
      end
      s_fetch: begin
        cmd_push      = !cmd_full;
        cmd_data.we   = 1'b0;
        cmd_data.addr = {req_tag, req_set, {OFFSET_BITS{1'b0}}};
        if (!cmd_full) state_d = s_fill_wait;
      end
      s_fill_wait: begin
        touch_way = victim_q;
        if (fill_valid) begin
          touch   = 1'b1;
          state_d = s_lookup;  // replay, hits this time
        end
      end
      s_write_cache: state_d = s_idle;
      s_respond: begin
        resp_valid = 1'b1;
        if (resp_ready) state_d = s_idle;  // stall here under back-pressure
      end
      default: state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= s_idle;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          tag_array[w][s] <= '0;
        end
      end
    end else begin
      state_q <= state_d;
      if (state_q == s_write_cache) begin
        tag_array[hit_way_q][req_set].dirty <= 1'b1;
      end
      if (state_q == s_fill_wait && fill_valid) begin
        tag_array[victim_q][req_set] <= '{valid: 1'b1, dirty: 1'b0, tag: req_tag};  // clean
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (req_pop) req_q <= req_head;
    if (state_q == s_lookup && hit) hit_way_q <= hit_way;
    if (state_q == s_lookup && !hit) victim_q <= plru_victim;  // held through the miss
  end

  always_ff @(posedge clk_in) begin
    if (state_q == s_write_cache) begin
      data_array[hit_way_q][req_set][req_word*`WORD_BITS +: `WORD_BITS] <= req_q.wdata;
    end
    if (state_q == s_fill_wait && fill_valid) begin
      data_array[victim_q][req_set] <= fill_line;
    end
  end

endmodule

// ==== src/plru_tree.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module plru_tree (
  input  logic                                                   clk_in,
  input  logic                                                   rst_N_in,
  input  logic [$clog2(`CACHE_BYTES/`LINE_BYTES/`CACHE_WAYS)-1:0] set_idx,
  input  logic                                                   touch,
  input  logic [$clog2(`CACHE_WAYS)-1:0]                          touch_way,
  output logic [$clog2(`CACHE_WAYS)-1:0]                          victim_way
);

  localparam int NUM_SETS  = `CACHE_BYTES / `LINE_BYTES / `CACHE_WAYS;
  localparam int WAY_BITS  = $clog2(`CACHE_WAYS);
  localparam int TREE_BITS = `CACHE_WAYS - 1;

  // heap order, node n has children 2n+1 and 2n+2
  // a zero bit points left
  logic [TREE_BITS-1:0] tree_q [NUM_SETS];
  logic [TREE_BITS-1:0] cur_bits;      // bits of the indexed set
  logic [TREE_BITS-1:0] touched_bits;  // same set after a touch
  int                   vic_node;
  int                   upd_node;

  assign cur_bits = tree_q[set_idx];

  // walk the tree where the bits point, msb of the way first
  always_comb begin
    vic_node   = 0;
    victim_way = '0;
    for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
      victim_way[WAY_BITS-1-lvl] = cur_bits[vic_node];
      vic_node = 2 * vic_node + 1 + int'(cur_bits[vic_node]);
    end
  end

  // along the touched way's path, point every node the other way
  always_comb begin
    upd_node     = 0;
    touched_bits = cur_bits;
    for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
      touched_bits[upd_node] = ~touch_way[WAY_BITS-1-lvl];
      upd_node = 2 * upd_node + 1 + int'(touch_way[WAY_BITS-1-lvl]);
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        tree_q[s] <= '0;  // every set starts at way 0
      end
    end else if (touch) begin
      tree_q[set_idx] <= touched_bits;
    end
  end

endmodule

// ==== src/req_fifo.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module req_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `FIFO_DEPTH
) (
  input  logic     clk_in,
  input  logic     rst_N_in,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  payload_t            slots [DEPTH];  // circular storage
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;  // occupancy
  logic                do_push;
  logic                do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = (count_q == CNT_BITS'(DEPTH));
  assign empty    = (count_q == '0);
  assign do_push  = push && !full;  // push into a full buffer is dropped
  assign do_pop   = pop && !empty;  // pop on empty does nothing
  assign pop_data = slots[rd_ptr_q];  // head shows the cycle after the push

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      slots[wr_ptr_q] <= push_data;
    end
  end

endmodule

// ==== src/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

  typedef logic [`ADDR_BITS-1:0] addr_t;  // byte address
  typedef logic [`WORD_BITS-1:0] word_t;
  typedef logic [`LINE_BYTES*8-1:0] line_t;  // whole cache line

  // host request, wdata ignored on reads
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } cache_req_t;

  // command to the backing memory
  typedef struct packed {
    logic  we;    // set for write-back, clear for line read
    addr_t addr;  // line aligned
    line_t data;  // only meaningful on write-back
  } mem_cmd_t;

  // one tag entry per way and set
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [`ADDR_BITS - $clog2(`CACHE_BYTES / `LINE_BYTES / `CACHE_WAYS)
           - $clog2(`LINE_BYTES) - 1:0] tag;
  } tag_entry_t;

endpackage

// ==== src/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address width
`define ADDR_BITS 16

// data word width
`define WORD_BITS 32

// line size in bytes, four words
`define LINE_BYTES 16

// capacity in bytes, 16 lines in all
`define CACHE_BYTES 256

// associativity, must be a power of two for the plru tree
`define CACHE_WAYS 4

`define MEM_LATENCY 4  // cycles per backing memory access

`define FIFO_DEPTH 4  // entries per buffer

`endif
